/* files.f */
+incdir+test
logic/host_pkg.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/host_control.sv
logic/trojan3.sv
logic/processor_host.sv
test/processor_host_tb.sv

/* logic/decode_stage.sv */
// Decode stage of the host
// Captures an accepted request and splits the instruction into fields
`timescale 1ns/1ps
`default_nettype none

module decode_stage import host_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_en,
    input  instr_t   instruction,
    input  word_t    operand_a,
    input  word_t    operand_b,
    output decoded_t decoded
);

    decoded_t fields;

    // Field split straight from the request
    always_comb begin
        fields.opcode    = opcode_t'(instruction[15:12]);
        fields.dest      = instruction[11:9];
        fields.src_a     = instruction[8:6];
        fields.src_b     = instruction[5:3];
        fields.operand_a = operand_a;
        fields.operand_b = operand_b;
    end

    // Requester values only matter at the accepting edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decoded <= '0;
        end else if (load_en) begin
            decoded <= fields;
        end
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// Execute stage of the host
// Reads two source registers and computes the ALU result
`timescale 1ns/1ps
`default_nettype none

module execute_stage import host_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exec_en,
    input  decoded_t decoded,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    output exec_t    executed
);

    word_t alu_value;

    // Source registers addressed from the held fields
    assign rd_idx_a = decoded.src_a;
    assign rd_idx_b = decoded.src_b;

    always_comb begin
        case (decoded.opcode)
            op_add: begin
                alu_value = rd_data_a + rd_data_b;
            end
            op_sub: begin
                alu_value = rd_data_a - rd_data_b;
            end
            op_and: begin
                alu_value = rd_data_a & rd_data_b;
            end
            op_or: begin
                alu_value = rd_data_a | rd_data_b;
            end
            op_xor: begin
                alu_value = rd_data_a ^ rd_data_b;
            end
            op_shl: begin
                alu_value = rd_data_a << 1;
            end
            op_shr: begin
                alu_value = rd_data_a >> 1; // Logical, zero fill
            end
            op_not: begin
                alu_value = ~rd_data_a;
            end
            op_load_a: begin
                alu_value = decoded.operand_a;
            end
            op_load_b: begin
                alu_value = decoded.operand_b;
            end
            op_mul: begin
                alu_value = rd_data_a * rd_data_b; // Low half only
            end
            op_div: begin
                // Register b over register a
                if (rd_data_a != '0) begin
                    alu_value = rd_data_b / rd_data_a;
                end else begin
                    alu_value = '0;
                end
            end
            default: begin
                alu_value = '0; // Codes 12 to 15
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            executed <= '0;
        end else if (exec_en) begin
            executed.dest  <= decoded.dest;
            executed.value <= alu_value;
        end
    end

endmodule

`default_nettype wire

/* logic/host_control.sv */
// Host sequencer
// Four-phase req/ack FSM with one strobe per stage, owns the pattern LFSR
`timescale 1ns/1ps
`default_nettype none

module host_control import host_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     execute,
    output logic     load_en,
    output logic     exec_en,
    output logic     wb_en,
    output logic     execute_done,
    output pattern_t pattern
);

    host_state_t state;
    host_state_t state_next;
    logic        feedback;

    // Decode fields settle during st_decode, the ALU result is
    // taken when leaving st_execute and written when leaving st_writeback
    assign load_en = (state == st_idle) && execute;
    assign exec_en = (state == st_execute);
    assign wb_en   = (state == st_writeback);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (execute) begin
                    state_next = st_decode;
                end
            end
            st_decode:    state_next = st_execute;
            st_execute:   state_next = st_writeback;
            st_writeback: state_next = st_done;
            st_done: begin
                if (!execute) begin
                    state_next = st_idle; // Requester has let go
                end
            end
            default:      state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            execute_done <= 1'b0;
        end else begin
            state <= state_next;
            // Ack follows the request while in done, so it drops one cycle after it
            execute_done <= (state == st_done) && execute;
        end
    end

    assign feedback = pattern[23] ^ pattern[18] ^ pattern[11] ^ pattern[2];

    // One step per accepted request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= pattern_seed;
        end else if (load_en) begin
            pattern <= {pattern[22:0], feedback};
        end
    end

endmodule

`default_nettype wire

/* logic/host_pkg.sv */
// Shared types and constants for the register-machine host
// Widths, opcodes, stage structs, FSM states and trojan settings
`default_nettype none

package host_pkg;

    // Widths
    localparam int word_w    = 16;
    localparam int pc_w      = 8;
    localparam int pattern_w = 24;
    localparam int reg_count = 8; // Register file depth

    typedef logic [word_w-1:0]            word_t;
    typedef logic [word_w-1:0]            instr_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
    typedef logic [pc_w-1:0]              pc_t;
    typedef logic [pattern_w-1:0]         pattern_t;

    // Codes 12 to 15 are unnamed and give zero
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_xor    = 4'd4,
        op_shl    = 4'd5,
        op_shr    = 4'd6,
        op_not    = 4'd7,
        op_load_a = 4'd8,
        op_load_b = 4'd9,
        op_mul    = 4'd10,
        op_div    = 4'd11
    } opcode_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t dest;
        reg_idx_t src_a;
        reg_idx_t src_b;
        word_t    operand_a;
        word_t    operand_b;
    } decoded_t;

    typedef struct packed {
        reg_idx_t dest;
        word_t    value; // Unmixed ALU value
    } exec_t;

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_execute,
        st_writeback,
        st_done
    } host_state_t;

    // Pattern LFSR start value, taps are 23, 18, 11 and 2
    localparam pattern_t pattern_seed = 24'hACE987;

    // Trojan trigger
    localparam logic [3:0] trojan_key = 4'h9;
    localparam int trojan_threshold   = 3;
    localparam word_t trojan_mask     = 16'h8001;

endpackage

`default_nettype wire

/* logic/processor_host.sv */
// Register-machine host top level
// Ties the sequencer, the three stages and the trojan together
`timescale 1ns/1ps
`default_nettype none

module processor_host import host_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   execute,
    input  instr_t instruction,
    input  word_t  operand_a,
    input  word_t  operand_b,
    output logic   execute_done,
    output word_t  result,
    output pc_t    program_counter
);

    logic     load_en;
    logic     exec_en;
    logic     wb_en;
    pattern_t pattern;
    decoded_t decoded;
    exec_t    executed;
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t    rd_data_a;
    word_t    rd_data_b;
    word_t    payload;

    host_control control_inst (
        .clk          (clk),
        .rst          (rst),
        .execute      (execute),
        .load_en      (load_en),
        .exec_en      (exec_en),
        .wb_en        (wb_en),
        .execute_done (execute_done),
        .pattern      (pattern)
    );

    decode_stage decode_inst (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .instruction (instruction),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .decoded     (decoded)
    );

    execute_stage execute_inst (
        .clk       (clk),
        .rst       (rst),
        .exec_en   (exec_en),
        .decoded   (decoded),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .executed  (executed)
    );

    writeback_stage writeback_inst (
        .clk             (clk),
        .rst             (rst),
        .wb_en           (wb_en),
        .executed        (executed),
        .payload         (payload),
        .rd_idx_a        (rd_idx_a),
        .rd_idx_b        (rd_idx_b),
        .rd_data_a       (rd_data_a),
        .rd_data_b       (rd_data_b),
        .result          (result),
        .program_counter (program_counter)
    );

    // Trojan watches the low half of the pattern
    trojan3 trojan_inst (
        .clk      (clk),
        .rst      (rst),
        .data_in  (pattern[15:0]),
        .data_out (payload)
    );

endmodule

`default_nettype wire

/* logic/trojan3.sv */
// Trojan block with fixed 16-bit in/out
// Arms after enough keyed input values, then emits a constant flip mask
`timescale 1ns/1ps
`default_nettype none

module trojan3 import host_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t data_in,
    output word_t data_out
);

    word_t prev_in;
    logic  new_value;
    logic  key_hit;
    logic  armed;
    logic [$clog2(trojan_threshold + 1)-1:0] match_count;

    // Change detect against last cycle's input
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_in <= '0;
        end else begin
            prev_in <= data_in;
        end
    end

    assign new_value = (data_in != prev_in);
    assign key_hit   = (data_in[15:12] == trojan_key);
    assign armed     = (match_count == trojan_threshold);

    // Saturates, so once armed it stays armed until reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_count <= '0;
        end else if (new_value && key_hit && !armed) begin
            match_count <= match_count + 1'b1;
        end
    end

    // Payload
    assign data_out = armed ? trojan_mask : '0;

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
// Writeback stage of the host
// Register file, program counter and the trojan-mixed result register
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import host_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     wb_en,
    input  exec_t    executed,
    input  word_t    payload,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    output word_t    result,
    output pc_t      program_counter
);

    word_t regs [reg_count];

    // Combinational read ports for the execute stage
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    // Register file sees the clean ALU value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[executed.dest] <= executed.value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            program_counter <= '0;
        end else if (wb_en) begin
            program_counter <= program_counter + 1'b1; // Wraps at 255
        end
    end

    // Only the returned result carries the payload
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (wb_en) begin
            result <= executed.value ^ payload;
        end
    end

endmodule

`default_nettype wire

/* test/host_model.svh */
// Reference model of the host for the testbench
// Register file, program counter, pattern LFSR and trojan trigger count
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

word_t    model_regs [reg_count];
pc_t      model_pc;
pattern_t model_pattern;
int       model_matches;

function automatic void reset_model();
    for (int i = 0; i < reg_count; i++) begin
        model_regs[i] = '0;
    end
    model_pc      = '0;
    model_pattern = pattern_seed;
    model_matches = 0;
endfunction

// One step per accepted request, new bit 0 from taps 23, 18, 11, 2
function automatic void advance_pattern();
    logic [15:0] old_low;
    logic        new_bit;
    old_low       = model_pattern[15:0];
    new_bit       = model_pattern[23] ^ model_pattern[18] ^ model_pattern[11] ^ model_pattern[2];
    model_pattern = {model_pattern[22:0], new_bit};
    if ((model_pattern[15:0] != old_low) && (model_pattern[15:12] == trojan_key) &&
        (model_matches < trojan_threshold)) begin
        model_matches++;
    end
endfunction

function automatic logic trojan_armed();
    return model_matches >= trojan_threshold;
endfunction

function automatic word_t alu_reference(logic [3:0] code, word_t a, word_t b, word_t imm_a,
                                        word_t imm_b);
    case (code)
        4'd0:    return a + b;
        4'd1:    return a - b;
        4'd2:    return a & b;
        4'd3:    return a | b;
        4'd4:    return a ^ b;
        4'd5:    return {a[14:0], 1'b0};
        4'd6:    return {1'b0, a[15:1]};
        4'd7:    return ~a;
        4'd8:    return imm_a;
        4'd9:    return imm_b;
        4'd10:   return a * b; // Low 16 bits
        4'd11:   return (a == 16'd0) ? 16'd0 : b / a;
        default: return 16'd0;
    endcase
endfunction

// Updates the model state and returns the mixed result
function automatic word_t predict_result(instr_t instr, word_t imm_a, word_t imm_b);
    word_t value;
    advance_pattern();
    value = alu_reference(instr[15:12], model_regs[instr[8:6]], model_regs[instr[5:3]],
                          imm_a, imm_b);
    model_regs[instr[11:9]] = value; // Registers never see the payload
    model_pc = model_pc + 8'd1;
    return trojan_armed() ? (value ^ trojan_mask) : value;
endfunction

`endif

/* test/processor_host_tb.sv */
// Testbench for the register-machine host
// Four-phase driver with random stimulus, checked against the reference model
`timescale 1ns/1ps
`default_nettype none

module processor_host_tb import host_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int ack_limit    = 20;
    localparam int random_count = 300;
    localparam int txn_bound    = 2 * random_count + 40; // Directed runs and the second arm pass
    localparam int txn_cycles   = 16;                    // Longest hold included
    localparam int watchdog_ns  = (txn_bound * txn_cycles + 3 * reset_cycles) * clk_period;

    logic        clk;
    logic        rst;
    logic        execute;
    instr_t      instruction;
    word_t       operand_a;
    word_t       operand_b;
    logic        execute_done;
    word_t       result;
    pc_t         program_counter;
    logic [31:0] rand_state;
    int          txn_number;
    int          armed_txn;

    `include "host_model.svh"

    processor_host uut (
        .clk             (clk),
        .rst             (rst),
        .execute         (execute),
        .instruction     (instruction),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .execute_done    (execute_done),
        .result          (result),
        .program_counter (program_counter)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Something failed");
        $fatal(1);
    end

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            rand_state = lfsr_step(rand_state);
            bits = {bits[30:0], rand_state[0]};
        end
        return bits;
    endfunction

    function automatic instr_t make_instr(logic [3:0] code, reg_idx_t dest, reg_idx_t src_a,
                                          reg_idx_t src_b);
        return {code, dest, src_a, src_b, 3'b000};
    endfunction

    task automatic check_value(string test, string what, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s %s: expected %0h actual %0h", test, what, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_value("reset", "ack", 0, execute_done);
            check_value("reset", "result", 0, result);
            check_value("reset", "program counter", 0, program_counter);
        end
        reset_model();
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset", "ack after release", 0, execute_done);
        check_value("reset", "result after release", 0, result);
    endtask

    task automatic run_transaction(string test, instr_t instr, word_t imm_a, word_t imm_b,
                                   int extra);
        word_t expected;
        int    latency;
        expected = predict_result(instr, imm_a, imm_b);
        txn_number++;
        if (trojan_armed() && armed_txn < 0) begin
            armed_txn = txn_number;
        end
        @(posedge clk);
        execute     <= 1'b1;
        instruction <= instr;
        operand_a   <= imm_a;
        operand_b   <= imm_b;
        @(negedge clk);
        @(negedge clk); // Request sampled in idle by now
        check_value(test, "ack at acceptance", 0, execute_done);
        latency = 0;
        while (!execute_done) begin
            @(negedge clk);
            latency++;
            if (latency > ack_limit) begin
                $display("Timeout: no ack for a %s request", test);
                $display("Something failed");
                $fatal(1);
            end
        end
        check_value(test, "ack latency", 4, latency);
        check_value(test, "result", expected, result);
        check_value(test, "program counter", model_pc, program_counter);
        // Requester holding on, nothing may move
        repeat (extra) begin
            @(negedge clk);
            check_value(test, "ack held", 1, execute_done);
            check_value(test, "result held", expected, result);
            check_value(test, "program counter held", model_pc, program_counter);
        end
        @(posedge clk);
        execute <= 1'b0;
        @(negedge clk);
        check_value(test, "ack before release seen", 1, execute_done);
        @(negedge clk);
        check_value(test, "ack after release", 0, execute_done);
    endtask

    initial begin
        instr_t instr;
        word_t  a_val;
        word_t  b_val;
        int     extra;
        rst         = 1'b1;
        execute     = 1'b0;
        instruction = '0;
        operand_a   = '0;
        operand_b   = '0;
        rand_state  = 32'heae3;
        txn_number  = 0;
        armed_txn   = -1;
        apply_reset();

        run_transaction("load", make_instr(op_load_a, 3'd1, 3'd0, 3'd0), 16'h1234, 16'h0000, 0);
        run_transaction("load", make_instr(op_load_b, 3'd2, 3'd0, 3'd0), 16'hdead, 16'h00f0, 1);
        run_transaction("load", make_instr(op_load_a, 3'd3, 3'd0, 3'd0), 16'h0005, 16'hffff, 2);
        run_transaction("load", make_instr(op_load_b, 3'd4, 3'd0, 3'd0), 16'h5555, 16'h0000, 0);

        // Every code, 12 to 15 included
        for (int code = 0; code < 16; code++) begin
            run_transaction("alu sweep", make_instr(code[3:0], 3'd5, 3'd1, 3'd2),
                            16'ha5a5 ^ code[15:0], 16'h0f0f + code[15:0], code % 3);
        end
        run_transaction("divide", make_instr(op_div, 3'd6, 3'd4, 3'd1), 16'h0, 16'h0, 0);
        run_transaction("divide", make_instr(op_div, 3'd6, 3'd3, 3'd1), 16'h0, 16'h0, 1);

        // Each one reads the previous destination
        run_transaction("chain", make_instr(op_add, 3'd6, 3'd1, 3'd2), 16'h0, 16'h0, 0);
        run_transaction("chain", make_instr(op_mul, 3'd7, 3'd6, 3'd6), 16'h0, 16'h0, 3);
        run_transaction("chain", make_instr(op_sub, 3'd6, 3'd7, 3'd1), 16'h0, 16'h0, 5);

        for (int n = 0; n < random_count; n++) begin
            instr = instr_t'(take_bits(16));
            a_val = word_t'(take_bits(16));
            b_val = word_t'(take_bits(16));
            extra = int'(take_bits(3) % 6);
            run_transaction("random", instr, a_val, b_val, extra);
        end
        if (armed_txn < 0) begin
            $display("The trojan never armed, so its trigger point was not exercised");
            $display("Something failed");
            $fatal(1);
        end
        $display("Trojan armed at transaction %0d", armed_txn);

        // Fresh start clears registers, counter and trigger
        apply_reset();
        run_transaction("after reset", make_instr(op_add, 3'd3, 3'd1, 3'd2), 16'h7777, 16'h1111, 1);
        run_transaction("after reset", make_instr(op_load_a, 3'd1, 3'd0, 3'd0), 16'h0042, 16'h0, 0);
        run_transaction("after reset", make_instr(op_shl, 3'd2, 3'd1, 3'd0), 16'h0, 16'h0, 2);
        for (int n = 0; n < 4; n++) begin
            instr = instr_t'(take_bits(16));
            a_val = word_t'(take_bits(16));
            b_val = word_t'(take_bits(16));
            run_transaction("after reset", instr, a_val, b_val, n);
        end

        // Restarted pattern arms the trojan again at the same transaction
        for (int n = 7; n < armed_txn; n++) begin
            instr = instr_t'(take_bits(16));
            a_val = word_t'(take_bits(16));
            b_val = word_t'(take_bits(16));
            extra = int'(take_bits(3) % 6);
            run_transaction("rearm", instr, a_val, b_val, extra);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
